//--- verilog/pmu_params.svh
`ifndef PMU_PARAMS_SVH
`define PMU_PARAMS_SVH

// --------------------------------------------------
// Widths and counts
// --------------------------------------------------
`define PMU_REG_WIDTH       32
`define PMU_N_COUNTERS      8
`define PMU_CNT_IDX_WIDTH   3
`define PMU_N_CORES         4
`define PMU_CORE_EVENTS     2
`define PMU_WEIGHT_WIDTH    8
`define PMU_ADDR_WIDTH      7

// --------------------------------------------------
// Register word indexes
// --------------------------------------------------
`define PMU_REG_CFG         0
`define PMU_REG_COUNTER0    1
`define PMU_REG_OVF_MASK    9
`define PMU_REG_OVF_VECT    10
`define PMU_REG_WEIGHTS0    11
`define PMU_REG_WEIGHTS1    12
`define PMU_REG_LIMIT0      13
`define PMU_REG_QUOTA0      17
`define PMU_N_REGS          21

// Configuration word bit positions
`define PMU_CFG_CNT_EN          0
`define PMU_CFG_CNT_SOFTRST     1
`define PMU_CFG_OVF_EN          2
`define PMU_CFG_OVF_SOFTRST     3
`define PMU_CFG_MCCU_EN         4
`define PMU_CFG_MCCU_SOFTRST    5
// One update bit per core, core 0 lowest
`define PMU_CFG_UPDATE_QUOTA0   6
`define PMU_CFG_SELFTEST_LO     30

`endif

//--- verilog/pmu_pkg.sv
package pmu_pkg;

    // Self-test event override
    typedef enum logic [1:0] {
        SELFTEST_NONE    = 2'b00,
        SELFTEST_ALL_ON  = 2'b01,
        SELFTEST_ALL_OFF = 2'b10,
        SELFTEST_ONE_ON  = 2'b11
    } selftest_e;

    // Write channel of the AXI4-Lite slave
    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_RESP = 1'b1
    } bus_state_e;

endpackage

//--- verilog/pmu_regs.sv
`timescale 1ns/1ns
`include "pmu_params.svh"

module pmu_regs (
    input  logic                                          clk_i,
    input  logic                                          rstn_i,
    input  logic [`PMU_ADDR_WIDTH-1:0]                    s_awaddr_i,
    input  logic                                          s_awvalid_i,
    output logic                                          s_awready_o,
    input  logic [`PMU_REG_WIDTH-1:0]                     s_wdata_i,
    input  logic [`PMU_REG_WIDTH/8-1:0]                   s_wstrb_i,
    input  logic                                          s_wvalid_i,
    output logic                                          s_wready_o,
    output logic [1:0]                                    s_bresp_o,
    output logic                                          s_bvalid_o,
    input  logic                                          s_bready_i,
    input  logic [`PMU_ADDR_WIDTH-1:0]                    s_araddr_i,
    input  logic                                          s_arvalid_i,
    output logic                                          s_arready_o,
    output logic [`PMU_REG_WIDTH-1:0]                     s_rdata_o,
    output logic [1:0]                                    s_rresp_o,
    output logic                                          s_rvalid_o,
    input  logic                                          s_rready_i,
    output logic                                          cnt_en_o,
    output logic                                          cnt_softrst_o,
    output logic                                          ovf_en_o,
    output logic                                          ovf_softrst_o,
    output pmu_pkg::selftest_e                            selftest_o,
    output logic [`PMU_N_COUNTERS-1:0]                    ovf_mask_o,
    output logic                                          mccu_en_o,
    output logic                                          mccu_softrst_o,
    output logic [`PMU_N_CORES-1:0]                       update_quota_o,
    output logic [`PMU_N_CORES*`PMU_CORE_EVENTS-1:0][`PMU_WEIGHT_WIDTH-1:0] weights_o,
    output logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0]   limits_o,
    output logic                                          cnt_load_valid_o,
    output logic [`PMU_CNT_IDX_WIDTH-1:0]                 cnt_load_idx_o,
    output logic [`PMU_REG_WIDTH-1:0]                     cnt_load_data_o,
    input  logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counter_val_i,
    input  logic [`PMU_N_COUNTERS-1:0]                    ovf_vect_i,
    input  logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0]   quota_i,
    input  logic [`PMU_N_CORES-1:0]                       exhausted_i,
    output logic                                          intr_overflow_o,
    output logic [`PMU_N_CORES-1:0]                       intr_mccu_o
);

    localparam int CORE_IDX_W = $clog2(`PMU_N_CORES);
    localparam int N_WEIGHT_REGS =
        `PMU_N_CORES * `PMU_CORE_EVENTS * `PMU_WEIGHT_WIDTH / `PMU_REG_WIDTH;

    // Word index from byte address
    logic [`PMU_ADDR_WIDTH-3:0] wr_idx;
    logic [`PMU_ADDR_WIDTH-3:0] rd_idx;

    pmu_pkg::bus_state_e wr_state_q;
    logic wr_fire;
    logic rd_fire;
    logic rvalid_q;
    logic [`PMU_REG_WIDTH-1:0] rdata_q;
    logic [`PMU_REG_WIDTH-1:0] rd_data;

    logic [`PMU_REG_WIDTH-1:0] cfg_q;
    logic [`PMU_N_COUNTERS-1:0] ovf_mask_q;
    logic [N_WEIGHT_REGS-1:0][`PMU_REG_WIDTH-1:0] weights_q;
    logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0] limits_q;

    assign wr_idx = s_awaddr_i[`PMU_ADDR_WIDTH-1:2];
    assign rd_idx = s_araddr_i[`PMU_ADDR_WIDTH-1:2];

    // --------------------------------------------------
    // AXI4-Lite handshakes
    // --------------------------------------------------
    // Address and data must arrive together, one write in flight
    assign wr_fire = s_awvalid_i && s_wvalid_i && (wr_state_q == pmu_pkg::BUS_IDLE);
    assign rd_fire = s_arvalid_i && !rvalid_q;

    assign s_awready_o = wr_fire;
    assign s_wready_o  = wr_fire;
    assign s_bvalid_o  = (wr_state_q == pmu_pkg::BUS_RESP);
    assign s_bresp_o   = 2'b00;
    assign s_arready_o = rd_fire;
    assign s_rvalid_o  = rvalid_q;
    assign s_rdata_o   = rdata_q;
    assign s_rresp_o   = 2'b00;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_state_q <= pmu_pkg::BUS_IDLE;
            rvalid_q   <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_state_q <= pmu_pkg::BUS_RESP;
            end else if (s_bready_i) begin
                wr_state_q <= pmu_pkg::BUS_IDLE;
            end
            // Response held until the master takes it
            if (rd_fire) begin
                rvalid_q <= 1'b1;
            end else if (s_rready_i) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Read data captured at acceptance
    always_ff @(posedge clk_i) begin
        if (rd_fire) begin
            rdata_q <= rd_data;
        end
    end

    // --------------------------------------------------
    // Register writes
    // --------------------------------------------------
    // Soft reset and update bits stay set until software clears them
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q      <= '0;
            ovf_mask_q <= '0;
            weights_q  <= '0;
            limits_q   <= '0;
        end else if (wr_fire) begin
            case (wr_idx) inside
                `PMU_REG_CFG:      cfg_q <= s_wdata_i;
                `PMU_REG_OVF_MASK: ovf_mask_q <= s_wdata_i[`PMU_N_COUNTERS-1:0];
                `PMU_REG_WEIGHTS0: weights_q[0] <= s_wdata_i;
                `PMU_REG_WEIGHTS1: weights_q[1] <= s_wdata_i;
                [`PMU_REG_LIMIT0:`PMU_REG_LIMIT0+`PMU_N_CORES-1]:
                    limits_q[CORE_IDX_W'(wr_idx - `PMU_REG_LIMIT0)] <= s_wdata_i;
                // Read-only and unmapped words drop the write
                default: ;
            endcase
        end
    end

    // Counter words are loaded inside the counter block
    assign cnt_load_valid_o = wr_fire && (wr_idx >= `PMU_REG_COUNTER0) &&
                              (wr_idx < `PMU_REG_COUNTER0 + `PMU_N_COUNTERS);
    assign cnt_load_idx_o   = `PMU_CNT_IDX_WIDTH'(wr_idx - `PMU_REG_COUNTER0);
    assign cnt_load_data_o  = s_wdata_i;

    // --------------------------------------------------
    // Readback
    // --------------------------------------------------
    always_comb begin
        rd_data = '0;
        case (rd_idx) inside
            `PMU_REG_CFG:      rd_data = cfg_q;
            [`PMU_REG_COUNTER0:`PMU_REG_COUNTER0+`PMU_N_COUNTERS-1]:
                rd_data = counter_val_i[`PMU_CNT_IDX_WIDTH'(rd_idx - `PMU_REG_COUNTER0)];
            `PMU_REG_OVF_MASK: rd_data = `PMU_REG_WIDTH'(ovf_mask_q);
            `PMU_REG_OVF_VECT: rd_data = `PMU_REG_WIDTH'(ovf_vect_i);
            `PMU_REG_WEIGHTS0: rd_data = weights_q[0];
            `PMU_REG_WEIGHTS1: rd_data = weights_q[1];
            [`PMU_REG_LIMIT0:`PMU_REG_LIMIT0+`PMU_N_CORES-1]:
                rd_data = limits_q[CORE_IDX_W'(rd_idx - `PMU_REG_LIMIT0)];
            [`PMU_REG_QUOTA0:`PMU_REG_QUOTA0+`PMU_N_CORES-1]:
                rd_data = quota_i[CORE_IDX_W'(rd_idx - `PMU_REG_QUOTA0)];
            default: rd_data = '0;
        endcase
    end

    // --------------------------------------------------
    // Configuration fields and interrupts
    // --------------------------------------------------
    assign cnt_en_o       = cfg_q[`PMU_CFG_CNT_EN];
    assign cnt_softrst_o  = cfg_q[`PMU_CFG_CNT_SOFTRST];
    assign ovf_en_o       = cfg_q[`PMU_CFG_OVF_EN];
    assign ovf_softrst_o  = cfg_q[`PMU_CFG_OVF_SOFTRST];
    assign mccu_en_o      = cfg_q[`PMU_CFG_MCCU_EN];
    assign mccu_softrst_o = cfg_q[`PMU_CFG_MCCU_SOFTRST];
    assign update_quota_o = cfg_q[`PMU_CFG_UPDATE_QUOTA0 +: `PMU_N_CORES];
    assign selftest_o     = pmu_pkg::selftest_e'(cfg_q[`PMU_CFG_SELFTEST_LO +: 2]);
    assign ovf_mask_o     = ovf_mask_q;
    assign weights_o      = weights_q;
    assign limits_o       = limits_q;

    // Masked sticky overflow, any source
    assign intr_overflow_o = |(ovf_vect_i & ovf_mask_q);
    // Per-core quota interrupt only while the MCCU runs
    assign intr_mccu_o = exhausted_i & {`PMU_N_CORES{mccu_en_o}};

endmodule

//--- verilog/pmu_event_counters.sv
`timescale 1ns/1ns
`include "pmu_params.svh"

module pmu_event_counters (
    input  logic                                           clk_i,
    input  logic                                           rstn_i,
    input  logic [`PMU_N_COUNTERS-1:0]                     events_i,
    input  pmu_pkg::selftest_e                             selftest_i,
    input  logic                                           cnt_en_i,
    input  logic                                           cnt_softrst_i,
    input  logic                                           ovf_en_i,
    input  logic                                           ovf_softrst_i,
    input  logic                                           cnt_load_valid_i,
    input  logic [`PMU_CNT_IDX_WIDTH-1:0]                  cnt_load_idx_i,
    input  logic [`PMU_REG_WIDTH-1:0]                      cnt_load_data_i,
    output logic [`PMU_N_COUNTERS-1:0]                     events_o,
    output logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counter_val_o,
    output logic [`PMU_N_COUNTERS-1:0]                     ovf_vect_o
);

    logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counter_q;
    logic [`PMU_N_COUNTERS-1:0] count_en;
    logic [`PMU_N_COUNTERS-1:0] load_hit;
    logic [`PMU_N_COUNTERS-1:0] wrap;
    logic [`PMU_N_COUNTERS-1:0] ovf_q;

    // --------------------------------------------------
    // Self-test event override
    // --------------------------------------------------
    always_comb begin
        case (selftest_i)
            pmu_pkg::SELFTEST_ALL_ON:  events_o = '1;
            pmu_pkg::SELFTEST_ALL_OFF: events_o = '0;
            pmu_pkg::SELFTEST_ONE_ON:  events_o = `PMU_N_COUNTERS'(1);
            default:                   events_o = events_i;
        endcase
    end

    // Per-counter increment, load and wrap conditions
    always_comb begin
        for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
            load_hit[i] = cnt_load_valid_i && (cnt_load_idx_i == `PMU_CNT_IDX_WIDTH'(i));
            count_en[i] = cnt_en_i && events_o[i];
            // Load wins, so a loaded counter never wraps
            wrap[i] = count_en[i] && !load_hit[i] && (counter_q[i] == '1);
        end
    end

    // --------------------------------------------------
    // Counters
    // --------------------------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            counter_q <= '0;
        end else if (cnt_softrst_i) begin
            counter_q <= '0;
        end else begin
            for (int i = 0; i < `PMU_N_COUNTERS; i++) begin
                if (load_hit[i]) begin
                    counter_q[i] <= cnt_load_data_i;
                end else if (count_en[i]) begin
                    counter_q[i] <= counter_q[i] + 1;
                end
            end
        end
    end

    // Sticky overflow, set on the wrapping edge
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            ovf_q <= '0;
        end else if (ovf_softrst_i) begin
            ovf_q <= '0;
        end else if (ovf_en_i && !cnt_softrst_i) begin
            ovf_q <= ovf_q | wrap;
        end
    end

    assign counter_val_o = counter_q;
    assign ovf_vect_o    = ovf_q;

endmodule

//--- verilog/pmu_mccu.sv
`timescale 1ns/1ns
`include "pmu_params.svh"

module pmu_mccu (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  logic [`PMU_N_COUNTERS-1:0]                  events_i,
    input  logic                                        mccu_en_i,
    input  logic                                        mccu_softrst_i,
    input  logic [`PMU_N_CORES-1:0]                     update_quota_i,
    input  logic [`PMU_N_CORES*`PMU_CORE_EVENTS-1:0][`PMU_WEIGHT_WIDTH-1:0] weights_i,
    input  logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0] limits_i,
    output logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0] quota_o,
    output logic [`PMU_N_CORES-1:0]                     exhausted_o
);

    // Room for the weight sum of one core
    localparam int SUM_W = `PMU_WEIGHT_WIDTH + $clog2(`PMU_CORE_EVENTS);

    for (genvar c = 0; c < `PMU_N_CORES; c++) begin : g_core
        logic [SUM_W-1:0] cost;
        logic [`PMU_REG_WIDTH-1:0] cost_ext;
        logic [`PMU_REG_WIDTH-1:0] quota_q;
        logic exhausted_q;

        // --------------------------------------------------
        // Weighted cost of this core's active events
        // --------------------------------------------------
        // Core c owns events c, c+N_CORES, ...
        always_comb begin
            cost = '0;
            for (int e = 0; e < `PMU_CORE_EVENTS; e++) begin
                if (events_i[c + e*`PMU_N_CORES]) begin
                    cost = cost + SUM_W'(weights_i[c*`PMU_CORE_EVENTS + e]);
                end
            end
        end

        assign cost_ext = `PMU_REG_WIDTH'(cost);

        // Budget, reloaded from the limit or drained toward zero
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                quota_q <= '0;
            end else if (mccu_softrst_i) begin
                quota_q <= '0;
            end else if (update_quota_i[c]) begin
                quota_q <= limits_i[c];
            end else if (mccu_en_i) begin
                // Saturate rather than underflow
                quota_q <= (quota_q > cost_ext) ? quota_q - cost_ext : '0;
            end
        end

        // Exhaustion flag trails the quota by a cycle
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                exhausted_q <= 1'b0;
            end else begin
                exhausted_q <= (quota_q == '0);
            end
        end

        assign quota_o[c]     = quota_q;
        assign exhausted_o[c] = exhausted_q;
    end

endmodule

//--- verilog/pmu_top.sv
`timescale 1ns/1ns
`include "pmu_params.svh"

module pmu_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic [`PMU_ADDR_WIDTH-1:0]    s_awaddr_i,
    input  logic                          s_awvalid_i,
    output logic                          s_awready_o,
    input  logic [`PMU_REG_WIDTH-1:0]     s_wdata_i,
    input  logic [`PMU_REG_WIDTH/8-1:0]   s_wstrb_i,
    input  logic                          s_wvalid_i,
    output logic                          s_wready_o,
    output logic [1:0]                    s_bresp_o,
    output logic                          s_bvalid_o,
    input  logic                          s_bready_i,
    input  logic [`PMU_ADDR_WIDTH-1:0]    s_araddr_i,
    input  logic                          s_arvalid_i,
    output logic                          s_arready_o,
    output logic [`PMU_REG_WIDTH-1:0]     s_rdata_o,
    output logic [1:0]                    s_rresp_o,
    output logic                          s_rvalid_o,
    input  logic                          s_rready_i,
    input  logic [`PMU_N_COUNTERS-1:0]    events_i,
    output logic                          intr_overflow_o,
    output logic [`PMU_N_CORES-1:0]       intr_mccu_o
);

    // --------------------------------------------------
    // Configuration from the register block
    // --------------------------------------------------
    logic cnt_en;
    logic cnt_softrst;
    logic ovf_en;
    logic ovf_softrst;
    pmu_pkg::selftest_e selftest;
    logic mccu_en;
    logic mccu_softrst;
    logic [`PMU_N_CORES-1:0] update_quota;
    logic [`PMU_N_CORES*`PMU_CORE_EVENTS-1:0][`PMU_WEIGHT_WIDTH-1:0] weights;
    logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0] limits;
    logic cnt_load_valid;
    logic [`PMU_CNT_IDX_WIDTH-1:0] cnt_load_idx;
    logic [`PMU_REG_WIDTH-1:0] cnt_load_data;

    // Results back to the register block
    logic [`PMU_N_COUNTERS-1:0] events_sel;
    logic [`PMU_N_COUNTERS-1:0][`PMU_REG_WIDTH-1:0] counter_val;
    logic [`PMU_N_COUNTERS-1:0] ovf_vect;
    logic [`PMU_N_CORES-1:0][`PMU_REG_WIDTH-1:0] quota;
    logic [`PMU_N_CORES-1:0] exhausted;

    // Mask is applied inside the register block
    pmu_regs u_regs (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .s_awaddr_i       (s_awaddr_i),
        .s_awvalid_i      (s_awvalid_i),
        .s_awready_o      (s_awready_o),
        .s_wdata_i        (s_wdata_i),
        .s_wstrb_i        (s_wstrb_i),
        .s_wvalid_i       (s_wvalid_i),
        .s_wready_o       (s_wready_o),
        .s_bresp_o        (s_bresp_o),
        .s_bvalid_o       (s_bvalid_o),
        .s_bready_i       (s_bready_i),
        .s_araddr_i       (s_araddr_i),
        .s_arvalid_i      (s_arvalid_i),
        .s_arready_o      (s_arready_o),
        .s_rdata_o        (s_rdata_o),
        .s_rresp_o        (s_rresp_o),
        .s_rvalid_o       (s_rvalid_o),
        .s_rready_i       (s_rready_i),
        .cnt_en_o         (cnt_en),
        .cnt_softrst_o    (cnt_softrst),
        .ovf_en_o         (ovf_en),
        .ovf_softrst_o    (ovf_softrst),
        .selftest_o       (selftest),
        .ovf_mask_o       (),
        .mccu_en_o        (mccu_en),
        .mccu_softrst_o   (mccu_softrst),
        .update_quota_o   (update_quota),
        .weights_o        (weights),
        .limits_o         (limits),
        .cnt_load_valid_o (cnt_load_valid),
        .cnt_load_idx_o   (cnt_load_idx),
        .cnt_load_data_o  (cnt_load_data),
        .counter_val_i    (counter_val),
        .ovf_vect_i       (ovf_vect),
        .quota_i          (quota),
        .exhausted_i      (exhausted),
        .intr_overflow_o  (intr_overflow_o),
        .intr_mccu_o      (intr_mccu_o)
    );

    // Counters and MCCU both see the self-test selected events
    pmu_event_counters u_counters (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .events_i         (events_i),
        .selftest_i       (selftest),
        .cnt_en_i         (cnt_en),
        .cnt_softrst_i    (cnt_softrst),
        .ovf_en_i         (ovf_en),
        .ovf_softrst_i    (ovf_softrst),
        .cnt_load_valid_i (cnt_load_valid),
        .cnt_load_idx_i   (cnt_load_idx),
        .cnt_load_data_i  (cnt_load_data),
        .events_o         (events_sel),
        .counter_val_o    (counter_val),
        .ovf_vect_o       (ovf_vect)
    );

    pmu_mccu u_mccu (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .events_i         (events_sel),
        .mccu_en_i        (mccu_en),
        .mccu_softrst_i   (mccu_softrst),
        .update_quota_i   (update_quota),
        .weights_i        (weights),
        .limits_i         (limits),
        .quota_o          (quota),
        .exhausted_o      (exhausted)
    );

endmodule

//--- test/pmu_tb.sv
`timescale 1ns/1ns
`include "pmu_params.svh"

module pmu_tb;

    // Watchdog, several times the length of the command file
    localparam int MAX_CYCLES = 2000;

    logic clk;
    logic rstn;
    logic [`PMU_ADDR_WIDTH-1:0] s_awaddr;
    logic s_awvalid;
    logic s_awready;
    logic [`PMU_REG_WIDTH-1:0] s_wdata;
    logic [`PMU_REG_WIDTH/8-1:0] s_wstrb;
    logic s_wvalid;
    logic s_wready;
    logic [1:0] s_bresp;
    logic s_bvalid;
    logic s_bready;
    logic [`PMU_ADDR_WIDTH-1:0] s_araddr;
    logic s_arvalid;
    logic s_arready;
    logic [`PMU_REG_WIDTH-1:0] s_rdata;
    logic [1:0] s_rresp;
    logic s_rvalid;
    logic s_rready;
    logic [`PMU_N_COUNTERS-1:0] events;
    logic intr_overflow;
    logic [`PMU_N_CORES-1:0] intr_mccu;

    int cycles = 0;
    int wr_cycle_last = 0;
    int wr_cycle_prev = 0;
    int fd;
    int n;
    logic [63:0] tok;
    logic [8*128-1:0] line;
    logic [31:0] arg_a;
    logic [31:0] arg_b;
    logic [31:0] rd;

    pmu_top dut (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .s_awaddr_i      (s_awaddr),
        .s_awvalid_i     (s_awvalid),
        .s_awready_o     (s_awready),
        .s_wdata_i       (s_wdata),
        .s_wstrb_i       (s_wstrb),
        .s_wvalid_i      (s_wvalid),
        .s_wready_o      (s_wready),
        .s_bresp_o       (s_bresp),
        .s_bvalid_o      (s_bvalid),
        .s_bready_i      (s_bready),
        .s_araddr_i      (s_araddr),
        .s_arvalid_i     (s_arvalid),
        .s_arready_o     (s_arready),
        .s_rdata_o       (s_rdata),
        .s_rresp_o       (s_rresp),
        .s_rvalid_o      (s_rvalid),
        .s_rready_i      (s_rready),
        .events_i        (events),
        .intr_overflow_o (intr_overflow),
        .intr_mccu_o     (intr_mccu)
    );

    // --------------------------------------------------
    // Clock and watchdog
    // --------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing the commands", cycles);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // --------------------------------------------------
    // AXI4-Lite master
    // --------------------------------------------------
    // Ready sampled mid-cycle, valid held until the slave takes it
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk);
        s_awaddr  = addr[`PMU_ADDR_WIDTH-1:0];
        s_wdata   = data;
        s_awvalid = 1'b1;
        s_wvalid  = 1'b1;
        #1;
        while (!(s_awready && s_wready)) begin
            @(negedge clk);
            #1;
        end
        // Acceptance cycles, used by window checks
        wr_cycle_prev = wr_cycle_last;
        wr_cycle_last = cycles;
        @(negedge clk);
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        while (!s_bvalid) @(negedge clk);
        check_value("bresp", 32'(s_bresp), 32'h0);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        @(negedge clk);
        s_araddr  = addr[`PMU_ADDR_WIDTH-1:0];
        s_arvalid = 1'b1;
        #1;
        while (!s_arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        s_arvalid = 1'b0;
        while (!s_rvalid) @(negedge clk);
        data = s_rdata;
        check_value("rresp", 32'(s_rresp), 32'h0);
    endtask

    task automatic hold_events(input logic [`PMU_N_COUNTERS-1:0] vec, input int len);
        @(negedge clk);
        events = vec;
        repeat (len) @(negedge clk);
        events = '0;
    endtask

    // One cycle for the registered quota flag to settle
    task automatic check_irqs(input logic [31:0] ovf, input logic [31:0] mccu);
        @(negedge clk);
        check_value("intr_overflow_o", 32'(intr_overflow), ovf);
        check_value("intr_mccu_o", 32'(intr_mccu), mccu);
    endtask

    // --------------------------------------------------
    // Command file
    // --------------------------------------------------
    initial begin
        rstn      = 1'b0;
        s_awaddr  = '0;
        s_awvalid = 1'b0;
        s_wdata   = '0;
        s_wstrb   = '1;
        s_wvalid  = 1'b0;
        s_bready  = 1'b1;
        s_araddr  = '0;
        s_arvalid = 1'b0;
        s_rready  = 1'b1;
        events    = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        fd = $fopen("test/pmu_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the command file test/pmu_testdata.txt");
            stop_run();
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok[7:0] == "#") begin
                n = $fgets(line, fd);
            end else begin
                n = $fscanf(fd, "%h %h", arg_a, arg_b);
                if (n != 2) begin
                    $display("Command %s in the data file lacks its two values", tok);
                    stop_run();
                end
                case (tok[7:0])
                    "W": bus_write(arg_a, arg_b);
                    "R": begin
                        bus_read(arg_a, rd);
                        check_value($sformatf("word at %h", arg_a), rd, arg_b);
                    end
                    // One count per cycle between the two last write acceptances
                    "T": begin
                        bus_read(arg_a, rd);
                        check_value($sformatf("counter at %h", arg_a), rd,
                                    arg_b + 32'(wr_cycle_last - wr_cycle_prev));
                    end
                    "E": hold_events(arg_a[`PMU_N_COUNTERS-1:0], arg_b);
                    "I": check_irqs(arg_a, arg_b);
                    default: begin
                        $display("Unknown command %s in the data file", tok);
                        stop_run();
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- test/pmu_testdata.txt
# Columns: cmd a b, values in hex. W addr data | R addr expected | E events cycles
# T addr base, expects base plus cycles between the last two writes | I overflow mccu
# Register access
R 00 00000000
R 50 00000000
W 24 000000a5
R 24 000000a5
W 2c 04030201
R 2c 04030201
W 30 08070605
R 30 08070605
W 40 00001234
R 40 00001234
W 28 ffffffff
R 28 00000000
W 44 ffffffff
R 44 00000000
W 54 deadbeef
R 54 00000000
W 00 00000001
R 00 00000001
# Counting and self-test
E 05 0a
R 04 0000000a
R 08 00000000
R 0c 0000000a
W 00 00000003
W 00 00000000
R 04 00000000
R 0c 00000000
W 00 40000000
W 00 40000001
W 00 40000000
T 04 00000000
T 20 00000000
W 00 00000002
W 00 c0000000
W 00 c0000001
W 00 c0000000
T 04 00000000
R 08 00000000
W 00 80000001
E ff 08
R 08 00000000
R 20 00000000
W 00 00000001
E 80 05
R 20 00000005
W 00 00000003
W 00 00000001
R 20 00000000
R 04 00000000
# Overflow
W 24 00000000
W 00 00000005
W 0c ffffffff
R 0c ffffffff
E 04 01
R 0c 00000000
R 28 00000004
I 0 0
W 24 00000004
I 1 0
W 00 0000000d
W 00 00000005
R 28 00000000
I 0 0
# Contention quota
W 34 00000064
W 38 00000014
W 3c 00000100
W 00 000003c5
W 00 00000015
R 44 00000064
R 48 00000014
R 4c 00000100
R 50 00001234
I 0 0
E 11 0a
R 44 00000046
R 48 00000014
# Quota exhaustion
E 22 03
R 48 00000000
I 0 2
R 44 00000046
W 00 00000005
I 0 0

//--- list.f
+incdir+verilog
verilog/pmu_pkg.sv
verilog/pmu_regs.sv
verilog/pmu_event_counters.sv
verilog/pmu_mccu.sv
verilog/pmu_top.sv
test/pmu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the PMU testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module pmu_tb -o pmu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/pmu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
